// File: trap_check_pkg.sv
//////////////////////////////////////////////////////////////////////
// Trap return-address checker definitions
// Widths, trap classes, RISC-V exception codes and the records for
// writeback, suppression and cause-save information
//////////////////////////////////////////////////////////////////////

package trap_check_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////////////////////////

  // PC and mepc are full words on RV32
  localparam int unsigned ADDR_W = 32;

  // Number of synchronous trap classes that are tracked
  localparam int unsigned NUM_TRAP_CLASSES = 6;

  // Width of the exception code field of mcause
  localparam int unsigned EXC_CODE_W = 5;

  // Trap classes
  // The enum value doubles as the bit position inside a class mask
  typedef enum logic [2:0] {
    CLS_MPU     = 3'd0,
    CLS_BUS     = 3'd1,
    CLS_ILLEGAL = 3'd2,
    CLS_ECALL_M = 3'd3,
    CLS_ECALL_U = 3'd4,
    CLS_EBREAK  = 3'd5
  } trap_class_e;

  // One bit per trap class
  typedef logic [NUM_TRAP_CLASSES-1:0] class_mask_t;

  // Only the two privilege levels of an M/U core exist
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  //////////////////////////////////////////////////////////////////////
  // Exception codes written to mcause
  //////////////////////////////////////////////////////////////////////

  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_INSTR_BUS_FAULT = 5'd1;
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_ILLEGAL_INSN    = 5'd2;
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_BREAKPOINT      = 5'd3;
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_ECALL_UMODE     = 5'd8;
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_ECALL_MMODE     = 5'd11;
  // Custom code the core uses for an MPU fault on instruction fetch
  localparam logic [EXC_CODE_W-1:0] EXC_CAUSE_INSTR_FAULT     = 5'd30;

  // Instruction leaving the writeback stage
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
    logic              illegal;
    logic              sys_en;
    logic              ecall;
    logic              ebreak;
    logic              bus_err;
    logic              mpu_err;
  } wb_instr_t;

  // Any set bit means the writeback record will not take its own trap
  typedef struct packed {
    logic irq_ack;
    logic debug_pending_allowed;
    logic debug_mode_next;
    logic nmi_trap;
  } trap_suppress_t;

  // Cause save as seen at the CSR file, with the mepc about to be written
  typedef struct packed {
    logic                  save;
    logic                  irq;
    logic [EXC_CODE_W-1:0] code;
    logic [ADDR_W-1:0]     mepc_next;
  } cause_save_t;

  // Registered classifier result shared by all slices
  typedef struct packed {
    class_mask_t       exp_mask;
    logic [ADDR_W-1:0] exp_pc;
    class_mask_t       act_mask;
    logic [ADDR_W-1:0] act_mepc;
  } trap_strobe_t;

endpackage

// File: trap_classifier.sv
//////////////////////////////////////////////////////////////////////
// Trap classifier
// Sorts writeback records and cause saves into trap classes and
// presents both results one cycle later as a single strobe
//////////////////////////////////////////////////////////////////////

module trap_classifier (
  input  logic                           clk,
  input  logic                           rst_ni,
  input  trap_check_pkg::wb_instr_t      wb_i,
  input  trap_check_pkg::trap_suppress_t supp_i,
  input  trap_check_pkg::priv_lvl_e      priv_i,
  input  trap_check_pkg::cause_save_t    cause_i,
  output trap_check_pkg::trap_strobe_t   strobe_o
);

  logic                              wb_qualified;
  logic                              cause_qualified;
  trap_check_pkg::class_mask_t       exp_mask_d;
  trap_check_pkg::class_mask_t       act_mask_d;
  trap_check_pkg::class_mask_t       exp_mask_q;
  trap_check_pkg::class_mask_t       act_mask_q;
  logic [trap_check_pkg::ADDR_W-1:0] exp_pc_q;
  logic [trap_check_pkg::ADDR_W-1:0] act_mepc_q;

  //////////////////////////////////////////////////////////////////////
  // Expected side
  //////////////////////////////////////////////////////////////////////

  // An interrupt, debug entry or NMI takes over the trap of this record
  assign wb_qualified = wb_i.valid && !supp_i.irq_ack && !supp_i.debug_pending_allowed &&
                        !supp_i.debug_mode_next && !supp_i.nmi_trap;

  // Fetch faults outrank decode faults, which outrank system instructions
  always_comb begin
    exp_mask_d = '0;
    if (wb_qualified) begin
      if (wb_i.mpu_err) begin
        exp_mask_d[trap_check_pkg::CLS_MPU] = 1'b1;
      end else if (wb_i.bus_err) begin
        exp_mask_d[trap_check_pkg::CLS_BUS] = 1'b1;
      end else if (wb_i.illegal) begin
        exp_mask_d[trap_check_pkg::CLS_ILLEGAL] = 1'b1;
      end else if (wb_i.sys_en && wb_i.ecall) begin
        // ECALL cause depends on the mode it was executed in
        case (priv_i)
          trap_check_pkg::PRIV_LVL_M: exp_mask_d[trap_check_pkg::CLS_ECALL_M] = 1'b1;
          trap_check_pkg::PRIV_LVL_U: exp_mask_d[trap_check_pkg::CLS_ECALL_U] = 1'b1;
          default:                    exp_mask_d = '0;
        endcase
      end else if (wb_i.sys_en && wb_i.ebreak) begin
        exp_mask_d[trap_check_pkg::CLS_EBREAK] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Actual side
  //////////////////////////////////////////////////////////////////////

  // Interrupt cause saves never belong to a synchronous class
  assign cause_qualified = cause_i.save && !cause_i.irq;

  always_comb begin
    act_mask_d = '0;
    if (cause_qualified) begin
      case (cause_i.code)
        trap_check_pkg::EXC_CAUSE_INSTR_FAULT: begin
          act_mask_d[trap_check_pkg::CLS_MPU] = 1'b1;
        end
        trap_check_pkg::EXC_CAUSE_INSTR_BUS_FAULT: begin
          act_mask_d[trap_check_pkg::CLS_BUS] = 1'b1;
        end
        trap_check_pkg::EXC_CAUSE_ILLEGAL_INSN: begin
          act_mask_d[trap_check_pkg::CLS_ILLEGAL] = 1'b1;
        end
        trap_check_pkg::EXC_CAUSE_ECALL_MMODE: begin
          act_mask_d[trap_check_pkg::CLS_ECALL_M] = 1'b1;
        end
        trap_check_pkg::EXC_CAUSE_ECALL_UMODE: begin
          act_mask_d[trap_check_pkg::CLS_ECALL_U] = 1'b1;
        end
        trap_check_pkg::EXC_CAUSE_BREAKPOINT: begin
          act_mask_d[trap_check_pkg::CLS_EBREAK] = 1'b1;
        end
        // Codes outside the six tracked classes are dropped here
        default: act_mask_d = '0;
      endcase
    end
  end

  // Masks qualify the captured addresses
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      exp_mask_q <= '0;
      act_mask_q <= '0;
    end else begin
      exp_mask_q <= exp_mask_d;
      act_mask_q <= act_mask_d;
    end
  end

  always_ff @(posedge clk) begin
    exp_pc_q   <= wb_i.pc;
    act_mepc_q <= cause_i.mepc_next;
  end

  assign strobe_o.exp_mask = exp_mask_q;
  assign strobe_o.exp_pc   = exp_pc_q;
  assign strobe_o.act_mask = act_mask_q;
  assign strobe_o.act_mepc = act_mepc_q;

  // A record or a cause save lands in at most one class
  a_strobe_onehot : assert property (
    @(posedge clk) disable iff (!rst_ni)
    $onehot0(strobe_o.exp_mask) && $onehot0(strobe_o.act_mask))
    else $error("trap_classifier: strobe selects more than one class");

endmodule

// File: trap_slice.sv
//////////////////////////////////////////////////////////////////////
// Trap slice
// Keeps the first expected PC and the first saved mepc of one trap
// class and compares them once both are known
//////////////////////////////////////////////////////////////////////

module trap_slice (
  input  logic                         clk,
  input  logic                         rst_ni,
  input  trap_check_pkg::trap_strobe_t strobe_i,
  input  trap_check_pkg::trap_class_e  cls_i,
  output logic                         checked_o,
  output logic                         mismatch_o
);

  logic                              exp_hit;
  logic                              act_hit;
  logic                              exp_found_q;
  logic                              act_found_q;
  logic [trap_check_pkg::ADDR_W-1:0] exp_pc_q;
  logic [trap_check_pkg::ADDR_W-1:0] act_mepc_q;
  logic                              both_found;
  logic                              checked_q;
  logic                              mismatch_q;

  // This slice only listens to its own class bit
  assign exp_hit = strobe_i.exp_mask[cls_i];
  assign act_hit = strobe_i.act_mask[cls_i];

  //////////////////////////////////////////////////////////////////////
  // First-occurrence capture
  //////////////////////////////////////////////////////////////////////

  // Found flags are set once and then hold until reset
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      exp_found_q <= 1'b0;
      act_found_q <= 1'b0;
    end else begin
      if (exp_hit) begin
        exp_found_q <= 1'b1;
      end
      if (act_hit) begin
        act_found_q <= 1'b1;
      end
    end
  end

  // Later occurrences of the same class leave the stored values alone
  always_ff @(posedge clk) begin
    if (exp_hit && !exp_found_q) begin
      exp_pc_q <= strobe_i.exp_pc;
    end
    if (act_hit && !act_found_q) begin
      act_mepc_q <= strobe_i.act_mepc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  assign both_found = exp_found_q && act_found_q;

  // Both stored values are frozen once found, so the result stays put
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      checked_q  <= 1'b0;
      mismatch_q <= 1'b0;
    end else begin
      checked_q  <= both_found;
      mismatch_q <= both_found && (exp_pc_q != act_mepc_q);
    end
  end

  assign checked_o  = checked_q;
  assign mismatch_o = mismatch_q;

  // A mismatch only follows a cycle in which both sides were stored
  a_mismatch_needs_check : assert property (
    @(posedge clk) disable iff (!rst_ni)
    $rose(mismatch_o) |-> checked_o && $past(both_found))
    else $error("trap_slice: mismatch raised for class %0d without a check", cls_i);

endmodule

// File: trap_report.sv
//////////////////////////////////////////////////////////////////////
// Trap report
// Turns the per-class slice results into sticky masks, a count of
// mismatching classes and an all-classes-checked level
//////////////////////////////////////////////////////////////////////

module trap_report (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  trap_check_pkg::class_mask_t checked_i,
  input  trap_check_pkg::class_mask_t mismatch_i,
  output trap_check_pkg::class_mask_t checked_o,
  output trap_check_pkg::class_mask_t mismatch_o,
  output logic [2:0]                  mismatch_cnt_o,
  output logic                        all_checked_o
);

  trap_check_pkg::class_mask_t checked_q;
  trap_check_pkg::class_mask_t mismatch_q;
  trap_check_pkg::class_mask_t new_mismatch;
  logic [2:0]                  new_cnt;
  logic [2:0]                  mismatch_cnt_q;
  logic                        all_checked_q;

  // A class contributes to the count only on its first mismatch
  assign new_mismatch = mismatch_i & ~mismatch_q;

  // Number of classes that start mismatching in this cycle
  always_comb begin
    new_cnt = '0;
    for (int unsigned i = 0; i < trap_check_pkg::NUM_TRAP_CLASSES; i++) begin
      new_cnt = new_cnt + {2'b00, new_mismatch[i]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sticky result registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      checked_q      <= '0;
      mismatch_q     <= '0;
      mismatch_cnt_q <= '0;
      all_checked_q  <= 1'b0;
    end else begin
      checked_q      <= checked_q | checked_i;
      mismatch_q     <= mismatch_q | mismatch_i;
      // Six classes at most, so three bits never wrap
      mismatch_cnt_q <= mismatch_cnt_q + new_cnt;
      all_checked_q  <= &(checked_q | checked_i);
    end
  end

  assign checked_o      = checked_q;
  assign mismatch_o     = mismatch_q;
  assign mismatch_cnt_o = mismatch_cnt_q;
  assign all_checked_o  = all_checked_q;

  // The count only ever grows between resets
  a_cnt_monotonic : assert property (
    @(posedge clk) disable iff (!rst_ni)
    1'b1 |=> mismatch_cnt_q >= $past(mismatch_cnt_q))
    else $error("trap_report: mismatch count went down");

endmodule

// File: trap_mepc_checker.sv
//////////////////////////////////////////////////////////////////////
// Trap mepc checker top level
// Checks per trap class that the first saved mepc equals the PC of
// the first instruction that should have trapped in that class
//////////////////////////////////////////////////////////////////////

module trap_mepc_checker (
  input  logic                           clk,
  input  logic                           rst_ni,
  // Writeback and cause-save observation
  input  trap_check_pkg::wb_instr_t      wb_i,
  input  trap_check_pkg::trap_suppress_t supp_i,
  input  trap_check_pkg::priv_lvl_e      priv_i,
  input  trap_check_pkg::cause_save_t    cause_i,
  // Results
  output trap_check_pkg::class_mask_t    checked_o,
  output trap_check_pkg::class_mask_t    mismatch_o,
  output logic [2:0]                     mismatch_cnt_o,
  output logic                           all_checked_o
);

  trap_check_pkg::trap_strobe_t strobe;
  trap_check_pkg::class_mask_t  slice_checked;
  trap_check_pkg::class_mask_t  slice_mismatch;

  //////////////////////////////////////////////////////////////////////
  // Classification
  //////////////////////////////////////////////////////////////////////

  // First stage, one cycle after the inputs are sampled
  trap_classifier trap_classifier_i (
    .clk      (clk),
    .rst_ni   (rst_ni),
    .wb_i     (wb_i),
    .supp_i   (supp_i),
    .priv_i   (priv_i),
    .cause_i  (cause_i),
    .strobe_o (strobe)
  );

  //////////////////////////////////////////////////////////////////////
  // Per-class capture and compare
  //////////////////////////////////////////////////////////////////////

  // Slice i serves the class whose enum value is i
  for (genvar i = 0; i < trap_check_pkg::NUM_TRAP_CLASSES; i++) begin : gen_slices
    trap_slice trap_slice_i (
      .clk        (clk),
      .rst_ni     (rst_ni),
      .strobe_i   (strobe),
      .cls_i      (trap_check_pkg::trap_class_e'(3'(i))),
      .checked_o  (slice_checked[i]),
      .mismatch_o (slice_mismatch[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  // Last register stage in front of the outputs
  trap_report trap_report_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .checked_i      (slice_checked),
    .mismatch_i     (slice_mismatch),
    .checked_o      (checked_o),
    .mismatch_o     (mismatch_o),
    .mismatch_cnt_o (mismatch_cnt_o),
    .all_checked_o  (all_checked_o)
  );

endmodule

// File: trap_vectors.svh
//////////////////////////////////////////////////////////////////////
// Trap checker test vectors
// Stimulus table for the trap mepc checker with the cumulative
// results expected after each entry
//////////////////////////////////////////////////////////////////////

`ifndef TRAP_VECTORS_SVH
`define TRAP_VECTORS_SVH

// Columns: name, writeback record, suppress, privilege, cause save,
// expected checked mask, expected mismatch mask, expected count
// Mask bits from 5 down to 0: EBREAK, ECALL-U, ECALL-M, illegal, bus, MPU
// Exception codes: 1 bus, 2 illegal, 3 breakpoint, 8 ECALL-U, 11 ECALL-M, 30 MPU

task automatic load_vectors();
  add_vector("idle_no_events",
             make_wb(1'b0, 32'h0000_0000, F_NONE), SUPP_NONE, PRIV_M,
             make_cause(1'b0, 1'b0, 5'd0, 32'h0000_0000), 6'b000000, 6'b000000, 3'd0);
  // Comes before every pair, so a code that lands in any class would poison it
  add_vector("unknown_code",
             make_wb(1'b0, 32'h0000_0000, F_NONE), SUPP_NONE, PRIV_M,
             make_cause(1'b1, 1'b0, 5'd7, 32'h0000_0123), 6'b000000, 6'b000000, 3'd0);
  // MPU fault outranks the illegal flag of the same record
  add_vector("mpu_and_illegal",
             make_wb(1'b1, 32'h0000_0100, F_MPU | F_ILL), SUPP_NONE, PRIV_M,
             make_cause(1'b1, 1'b0, 5'd30, 32'h0000_0100), 6'b000001, 6'b000000, 3'd0);
  add_vector("bus_fault_match",
             make_wb(1'b1, 32'h0000_0200, F_BUS), SUPP_NONE, PRIV_M,
             make_cause(1'b1, 1'b0, 5'd1, 32'h0000_0200), 6'b000011, 6'b000000, 3'd0);
  // The next four entries would poison ECALL-M or EBREAK if not ignored
  add_vector("suppressed_ecall_m",
             make_wb(1'b1, 32'h0000_0300, F_SYS | F_ECALL), SUPP_IRQ, PRIV_M,
             make_cause(1'b0, 1'b0, 5'd0, 32'h0000_0000), 6'b000011, 6'b000000, 3'd0);
  add_vector("debug_ebreak",
             make_wb(1'b1, 32'h0000_0450, F_SYS | F_EBRK), SUPP_DBG, PRIV_M,
             make_cause(1'b0, 1'b0, 5'd0, 32'h0000_0000), 6'b000011, 6'b000000, 3'd0);
  add_vector("invalid_ebreak",
             make_wb(1'b0, 32'h0000_0400, F_SYS | F_EBRK), SUPP_NONE, PRIV_M,
             make_cause(1'b0, 1'b0, 5'd0, 32'h0000_0000), 6'b000011, 6'b000000, 3'd0);
  add_vector("irq_cause_save",
             make_wb(1'b0, 32'h0000_0000, F_NONE), SUPP_NONE, PRIV_M,
             make_cause(1'b1, 1'b1, 5'd11, 32'h0000_0999), 6'b000011, 6'b000000, 3'd0);
  add_vector("ecall_m_record",
             make_wb(1'b1, 32'h0000_0500, F_SYS | F_ECALL), SUPP_NONE, PRIV_M,
             make_cause(1'b0, 1'b0, 5'd0, 32'h0000_0000), 6'b000011, 6'b000000, 3'd0);
  add_vector("ecall_m_save",
             make_wb(1'b0, 32'h0000_0000, F_NONE), SUPP_NONE, PRIV_M,
             make_cause(1'b1, 1'b0, 5'd11, 32'h0000_0500), 6'b001011, 6'b000000, 3'd0);
  add_vector("ecall_u_mismatch",
             make_wb(1'b1, 32'h0000_0600, F_SYS | F_ECALL), SUPP_NONE, PRIV_U,
             make_cause(1'b1, 1'b0, 5'd8, 32'h0000_0604), 6'b011011, 6'b010000, 3'd1);
  // Cause save ahead of its record is held until the record shows up
  add_vector("ebreak_save_first",
             make_wb(1'b0, 32'h0000_0000, F_NONE), SUPP_NONE, PRIV_M,
             make_cause(1'b1, 1'b0, 5'd3, 32'h0000_0700), 6'b011011, 6'b010000, 3'd1);
  add_vector("ebreak_record",
             make_wb(1'b1, 32'h0000_0700, F_SYS | F_EBRK), SUPP_NONE, PRIV_M,
             make_cause(1'b0, 1'b0, 5'd0, 32'h0000_0000), 6'b111011, 6'b010000, 3'd1);
  add_vector("bus_second_pc",
             make_wb(1'b1, 32'h0000_0800, F_BUS), SUPP_NONE, PRIV_M,
             make_cause(1'b1, 1'b0, 5'd1, 32'h0000_0804), 6'b111011, 6'b010000, 3'd1);
  // Would mismatch if the MPU record above had also been taken as illegal
  add_vector("illegal_match",
             make_wb(1'b1, 32'h0000_0900, F_ILL), SUPP_NONE, PRIV_M,
             make_cause(1'b1, 1'b0, 5'd2, 32'h0000_0900), 6'b111111, 6'b010000, 3'd1);
  add_vector("illegal_second_pc",
             make_wb(1'b1, 32'h0000_0a00, F_ILL), SUPP_NONE, PRIV_M,
             make_cause(1'b1, 1'b0, 5'd2, 32'h0000_0a04), 6'b111111, 6'b010000, 3'd1);
endtask

`endif

// File: tb_trap_mepc_checker.sv
//////////////////////////////////////////////////////////////////////
// Trap mepc checker testbench
// Applies a table of writeback records and cause saves and checks
// the sticky result masks, mismatch count and completion level
//////////////////////////////////////////////////////////////////////

module tb_trap_mepc_checker;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED        = 32'haf7c_7b47;
  localparam int unsigned IDLE_CYCLES = 2;
  localparam int unsigned WAIT_CYCLES = 5;

  // Flag order {illegal, sys_en, ecall, ebreak, bus_err, mpu_err}
  localparam logic [5:0] F_NONE  = 6'b000000;
  localparam logic [5:0] F_ILL   = 6'b100000;
  localparam logic [5:0] F_SYS   = 6'b010000;
  localparam logic [5:0] F_ECALL = 6'b001000;
  localparam logic [5:0] F_EBRK  = 6'b000100;
  localparam logic [5:0] F_BUS   = 6'b000010;
  localparam logic [5:0] F_MPU   = 6'b000001;

  localparam trap_check_pkg::trap_suppress_t SUPP_NONE = 4'b0000;
  localparam trap_check_pkg::trap_suppress_t SUPP_IRQ  = 4'b1000;
  localparam trap_check_pkg::trap_suppress_t SUPP_DBG  = 4'b0010;
  localparam trap_check_pkg::priv_lvl_e PRIV_M = trap_check_pkg::PRIV_LVL_M;
  localparam trap_check_pkg::priv_lvl_e PRIV_U = trap_check_pkg::PRIV_LVL_U;

  typedef struct {
    string                          name;
    trap_check_pkg::wb_instr_t      wb;
    trap_check_pkg::trap_suppress_t supp;
    trap_check_pkg::priv_lvl_e      priv;
    trap_check_pkg::cause_save_t    cause;
    trap_check_pkg::class_mask_t    exp_checked;
    trap_check_pkg::class_mask_t    exp_mismatch;
    logic [2:0]                     exp_cnt;
  } vector_t;

  logic                           clk = 1'b0;
  logic                           rst_ni;
  trap_check_pkg::wb_instr_t      wb;
  trap_check_pkg::trap_suppress_t supp;
  trap_check_pkg::priv_lvl_e      priv;
  trap_check_pkg::cause_save_t    cause;
  trap_check_pkg::class_mask_t    checked;
  trap_check_pkg::class_mask_t    mismatch;
  logic [2:0]                     mismatch_cnt;
  logic                           all_checked;

  vector_t     vectors[$];
  logic        vectors_loaded = 1'b0;
  int unsigned num_checks     = 0;
  int unsigned mask_errors    = 0;
  int unsigned count_errors   = 0;
  int unsigned level_errors   = 0;

  always #5 clk = ~clk;

  trap_mepc_checker trap_mepc_checker_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .wb_i           (wb),
    .supp_i         (supp),
    .priv_i         (priv),
    .cause_i        (cause),
    .checked_o      (checked),
    .mismatch_o     (mismatch),
    .mismatch_cnt_o (mismatch_cnt),
    .all_checked_o  (all_checked)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic trap_check_pkg::wb_instr_t make_wb(logic valid, logic [31:0] pc,
                                                        logic [5:0] flags);
    trap_check_pkg::wb_instr_t rec;
    rec.valid   = valid;
    rec.pc      = pc;
    rec.illegal = flags[5];
    rec.sys_en  = flags[4];
    rec.ecall   = flags[3];
    rec.ebreak  = flags[2];
    rec.bus_err = flags[1];
    rec.mpu_err = flags[0];
    return rec;
  endfunction

  function automatic trap_check_pkg::cause_save_t make_cause(logic save, logic irq,
                                                             logic [4:0] code,
                                                             logic [31:0] mepc);
    trap_check_pkg::cause_save_t ev;
    ev.save      = save;
    ev.irq       = irq;
    ev.code      = code;
    ev.mepc_next = mepc;
    return ev;
  endfunction

  function automatic void add_vector(string name, trap_check_pkg::wb_instr_t rec,
                                     trap_check_pkg::trap_suppress_t sup,
                                     trap_check_pkg::priv_lvl_e pl,
                                     trap_check_pkg::cause_save_t ev,
                                     trap_check_pkg::class_mask_t exp_chk,
                                     trap_check_pkg::class_mask_t exp_mis,
                                     logic [2:0] exp_cnt);
    vector_t v;
    v.name         = name;
    v.wb           = rec;
    v.supp         = sup;
    v.priv         = pl;
    v.cause        = ev;
    v.exp_checked  = exp_chk;
    v.exp_mismatch = exp_mis;
    v.exp_cnt      = exp_cnt;
    vectors.push_back(v);
  endfunction

  `include "trap_vectors.svh"

  // Filler cycle with no event and a random PC on the idle record
  task automatic drive_idle();
    wb       = make_wb(1'b0, $urandom(), F_NONE);
    supp     = SUPP_NONE;
    priv     = PRIV_M;
    cause    = make_cause(1'b0, 1'b0, 5'd0, 32'h0000_0000);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_mask(string test, string what, trap_check_pkg::class_mask_t exp,
                            trap_check_pkg::class_mask_t act);
    num_checks++;
    if (act !== exp) begin
      $display("ERR %s %s: expected %b, actual %b", test, what, exp, act);
      mask_errors++;
    end
  endtask

  task automatic check_count(string test, logic [2:0] exp, logic [2:0] act);
    num_checks++;
    if (act !== exp) begin
      $display("ERR %s mismatch count: expected %0d, actual %0d", test, exp, act);
      count_errors++;
    end
  endtask

  task automatic check_flag(string test, logic exp, logic act);
    num_checks++;
    if (act !== exp) begin
      $display("ERR %s all_checked: expected %b, actual %b", test, exp, act);
      level_errors++;
    end
  endtask

  // All six classes checked means the completion level is up
  task automatic check_outputs(string test, trap_check_pkg::class_mask_t exp_chk,
                               trap_check_pkg::class_mask_t exp_mis, logic [2:0] exp_cnt);
    check_mask(test, "checked", exp_chk, checked);
    check_mask(test, "mismatch", exp_mis, mismatch);
    check_count(test, exp_cnt, mismatch_cnt);
    check_flag(test, &exp_chk, all_checked);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned seed_init;
    seed_init = $urandom(SEED);
    rst_ni    = 1'b0;
    drive_idle();
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst_ni = 1'b1;
    @(posedge clk);
    #1 check_outputs("after_reset", '0, '0, 3'd0);
    foreach (vectors[i]) begin
      wb    = vectors[i].wb;
      supp  = vectors[i].supp;
      priv  = vectors[i].priv;
      cause = vectors[i].cause;
      repeat (1 + IDLE_CYCLES) begin
        @(posedge clk);
        #1 drive_idle();
      end
      repeat (WAIT_CYCLES) @(posedge clk);
      #1 check_outputs(vectors[i].name, vectors[i].exp_checked, vectors[i].exp_mismatch,
                       vectors[i].exp_cnt);
    end
    $display("Checks: %0d, mask errors: %0d, count errors: %0d, level errors: %0d",
             num_checks, mask_errors, count_errors, level_errors);
    if (mask_errors + count_errors + level_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Each entry takes 8 cycles, the rest covers reset and the first check
  initial begin
    wait (vectors_loaded);
    repeat (vectors.size() * 8 + 20) @(posedge clk);
    $display("Timeout: the test sequence did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+.
trap_check_pkg.sv
trap_classifier.sv
trap_slice.sv
trap_report.sv
trap_mepc_checker.sv
tb_trap_mepc_checker.sv
